// ==== design/nf_pkg.sv ====
// Shared bus widths, AXI response codes and the register map of the host bridge stand-in
// Also holds the vector typedefs used on the control and data planes
package nf_pkg;

  // AXI4-Lite control plane
  typedef logic [31:0] axil_addr_t;  // Byte address on the control bus
  typedef logic [31:0] axil_data_t;  // One register word
  typedef logic [3:0]  axil_strb_t;  // One strobe bit per data byte
  typedef logic [1:0]  axi_resp_t;   // BRESP and RRESP encoding

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;  // Used for bad offsets and read-only writes

  // Stream sideband that travels with every beat
  typedef logic [15:0] pkt_len_t;  // Packet length in bytes
  typedef logic [7:0]  port_t;     // Source or destination port number

  // Packet counters simply wrap at the top
  typedef logic [31:0] cnt_t;

  // Register map as byte offsets of 32-bit words
  localparam axil_addr_t REG_ID       = 32'h0000_0000;  // Read-only design identifier
  localparam axil_addr_t REG_SCRATCH  = 32'h0000_0004;  // Free read/write word
  localparam axil_addr_t REG_CTRL     = 32'h0000_0008;  // Loopback control bits
  localparam axil_addr_t REG_FWD_CNT  = 32'h0000_000C;  // Packets sent to egress
  localparam axil_addr_t REG_DROP_CNT = 32'h0000_0010;  // Packets discarded on error

  // Bit positions inside the control register
  localparam int CTRL_SWAP_BIT = 0;  // Exchange source and destination ports
  localparam int CTRL_DROP_BIT = 1;  // Discard packets that carry the error flag

  // Value returned from REG_ID
  // Reads as "NF10" in ASCII
  localparam axil_data_t DESIGN_ID = 32'h4E46_3130;

endpackage

// ==== design/beat_fifo.sv ====
// Synchronous FIFO of stream beats built on a register array
// Shows the head word before it is popped and flags full and empty
`timescale 1ns/1ns

module beat_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 8   // Power of two
) (
  input  logic             ACLK,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);  // Count must reach DEPTH itself

  logic [WIDTH-1:0] mem [DEPTH];  // Beat storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // Words held right now

  assign pop_data = mem[rd_ptr];  // Head word is visible without a pop
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);

  // Beat storage is written at the tail slot
  always_ff @(posedge ACLK) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  // Pointers wrap back to zero at the last slot
  always_ff @(posedge ACLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither leave the level unchanged
      endcase
    end
  end

  // The user of the FIFO owns flow control on both sides
  a_no_overflow : assert property (@(posedge ACLK) disable iff (!rst_n) push |-> !full);
  a_no_underflow : assert property (@(posedge ACLK) disable iff (!rst_n) pop |-> !empty);

endmodule

// ==== design/ctrl_regs.sv ====
// AXI4-Lite slave for the control plane of the bridge stand-in
// Holds the ID, scratch and control words and reads back the loopback packet counters
`timescale 1ns/1ns

module ctrl_regs
  import nf_pkg::*;
(
  input  logic       ACLK,
  input  logic       rst_n,
  // Write address and data channels
  input  axil_addr_t s_axi_awaddr,
  input  logic [2:0] s_axi_awprot,   // Taken with the address and otherwise ignored
  input  logic       s_axi_awvalid,
  output logic       s_axi_awready,
  input  axil_data_t s_axi_wdata,
  input  axil_strb_t s_axi_wstrb,
  input  logic       s_axi_wvalid,
  output logic       s_axi_wready,
  // Write response channel
  output axi_resp_t  s_axi_bresp,
  output logic       s_axi_bvalid,
  input  logic       s_axi_bready,
  // Read address channel
  input  axil_addr_t s_axi_araddr,
  input  logic [2:0] s_axi_arprot,   // Same treatment as awprot
  input  logic       s_axi_arvalid,
  output logic       s_axi_arready,
  // Read data channel
  output axil_data_t s_axi_rdata,
  output axi_resp_t  s_axi_rresp,
  output logic       s_axi_rvalid,
  input  logic       s_axi_rready,
  // Data plane status and control
  input  cnt_t       fwd_cnt,
  input  cnt_t       drop_cnt,
  output logic       swap_en,
  output logic       drop_en,
  output axil_data_t debug_vec
);

  axil_data_t scratch_q;  // Scratch word with per-byte write strobes
  logic [7:0] ctrl_q;     // Only byte 0 of the control register is implemented
  axil_data_t ctrl_word;  // Control byte widened to a full register word
  logic       wr_acc;     // Address and data taken this cycle
  logic       rd_acc;     // Read address taken this cycle
  axil_data_t rd_data;
  axi_resp_t  rd_resp;

  // Both write channels must be present together and the previous response gone
  assign wr_acc = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign rd_acc = s_axi_arvalid & ~s_axi_rvalid;  // One read in flight at a time

  assign s_axi_awready = wr_acc;
  assign s_axi_wready  = wr_acc;  // Pulses together with awready
  assign s_axi_arready = rd_acc;

  assign ctrl_word = {{($bits(axil_data_t) - 8){1'b0}}, ctrl_q};

  // Control bits go straight out to the loopback
  assign swap_en = ctrl_q[CTRL_SWAP_BIT];
  assign drop_en = ctrl_q[CTRL_DROP_BIT];

  assign debug_vec = scratch_q ^ ctrl_word;  // Folded into the parity pin at the top level

  // Register updates and the write response handshake
  always_ff @(posedge ACLK or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q    <= '0;
      ctrl_q       <= '0;
      s_axi_bvalid <= 1'b0;
    end else if (wr_acc) begin
      s_axi_bvalid <= 1'b1;  // Response appears the cycle after acceptance
      case (s_axi_awaddr)
        REG_SCRATCH: begin
          for (int i = 0; i < $bits(axil_strb_t); i++) begin
            if (s_axi_wstrb[i]) scratch_q[8*i +: 8] <= s_axi_wdata[8*i +: 8];
          end
        end
        REG_CTRL: if (s_axi_wstrb[0]) ctrl_q <= s_axi_wdata[7:0];  // Upper strobes do nothing
        default: ;  // ID, counters and holes stay untouched
      endcase
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  // Write response code is decided at acceptance and held until bready
  always_ff @(posedge ACLK) begin
    if (wr_acc) begin
      if (s_axi_awaddr == REG_SCRATCH || s_axi_awaddr == REG_CTRL) s_axi_bresp <= RESP_OKAY;
      else s_axi_bresp <= RESP_SLVERR;
    end
  end

  // Read decode of the register map
  always_comb begin
    rd_resp = RESP_OKAY;
    case (s_axi_araddr)
      REG_ID:       rd_data = DESIGN_ID;
      REG_SCRATCH:  rd_data = scratch_q;
      REG_CTRL:     rd_data = ctrl_word;
      REG_FWD_CNT:  rd_data = fwd_cnt;   // Live counter value at the time of the read
      REG_DROP_CNT: rd_data = drop_cnt;
      default: begin
        rd_data = '0;  // Holes read as zero
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  // Read response valid flag
  always_ff @(posedge ACLK or negedge rst_n) begin
    if (!rst_n) s_axi_rvalid <= 1'b0;
    else if (rd_acc) s_axi_rvalid <= 1'b1;
    else if (s_axi_rready) s_axi_rvalid <= 1'b0;
  end

  // Read payload is captured once and held while the master stalls
  always_ff @(posedge ACLK) begin
    if (rd_acc) begin
      s_axi_rdata <= rd_data;
      s_axi_rresp <= rd_resp;
    end
  end

  // Responses must not change while the master holds off ready
  a_bresp_stable : assert property (@(posedge ACLK) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));
  a_rdata_stable : assert property (@(posedge ACLK) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// ==== design/stream_loopback.sv ====
// AXI4-Stream packet loopback from ingress to egress with its sideband
// Optional port swap and error drop per packet plus forward and drop counters
`timescale 1ns/1ns

module stream_loopback
  import nf_pkg::*;
#(
  parameter int DATA_W     = 64,  // Multiple of 8
  parameter int FIFO_DEPTH = 8
) (
  input  logic                ACLK,
  input  logic                rst_n,
  // Ingress stream
  input  logic [DATA_W-1:0]   s_axis_tdata,
  input  logic [DATA_W/8-1:0] s_axis_tstrb,
  input  logic                s_axis_tlast,
  input  logic                s_axis_tvalid,
  output logic                s_axis_tready,
  input  pkt_len_t            s_axis_len,
  input  port_t               s_axis_spt,
  input  port_t               s_axis_dpt,
  input  logic                s_axis_err,
  // Egress stream
  output logic [DATA_W-1:0]   m_axis_tdata,
  output logic [DATA_W/8-1:0] m_axis_tstrb,
  output logic                m_axis_tlast,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output pkt_len_t            m_axis_len,
  output port_t               m_axis_spt,
  output port_t               m_axis_dpt,
  output logic                m_axis_err,
  // Control and status
  input  logic                swap_en,
  input  logic                drop_en,
  output cnt_t                fwd_cnt,
  output cnt_t                drop_cnt
);

  localparam int STRB_W = DATA_W / 8;
  localparam int SIDE_W = $bits(pkt_len_t) + 2 * $bits(port_t) + 1;  // len, spt, dpt, err
  localparam int BEAT_W = DATA_W + STRB_W + 1 + SIDE_W;

  // Where the ingress stands within a packet
  typedef enum logic [1:0] {
    HEAD,       // Next beat opens a packet
    BODY_FWD,   // Inside a packet going to egress
    BODY_DROP   // Inside a packet being discarded
  } pkt_state_t;

  pkt_state_t        state_q;
  logic              ready_en_q;  // Holds tready low for the first cycle out of reset
  logic              in_acc;      // Ingress beat taken this cycle
  logic              drop_now;    // Current beat belongs to a dropped packet
  logic              push;
  logic              pop;
  logic              full;
  logic              empty;
  port_t             spt_head;    // Ports of the head beat after the optional swap
  port_t             dpt_head;
  logic [SIDE_W-1:0] side_head;   // Sideband as taken from the head beat
  logic [SIDE_W-1:0] side_q;      // Sideband held for the rest of the packet
  logic [SIDE_W-1:0] side_cur;
  logic [BEAT_W-1:0] push_beat;
  logic [BEAT_W-1:0] pop_beat;

  assign s_axis_tready = ready_en_q & ~full;
  assign in_acc        = s_axis_tvalid & s_axis_tready;

  // Swap is decided from the control bit seen with the head beat
  assign spt_head  = swap_en ? s_axis_dpt : s_axis_spt;
  assign dpt_head  = swap_en ? s_axis_spt : s_axis_dpt;
  assign side_head = {s_axis_len, spt_head, dpt_head, s_axis_err};

  // On the head beat the decision is live; after that the state carries it
  assign drop_now = (state_q == HEAD) ? (drop_en & s_axis_err) : (state_q == BODY_DROP);
  assign side_cur = (state_q == HEAD) ? side_head : side_q;

  assign push      = in_acc & ~drop_now;  // Dropped beats are accepted and vanish
  assign push_beat = {s_axis_tdata, s_axis_tstrb, s_axis_tlast, side_cur};

  beat_fifo #(
    .WIDTH (BEAT_W),
    .DEPTH (FIFO_DEPTH)
  ) beat_fifo_inst (
    .ACLK      (ACLK),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_beat),
    .pop       (pop),
    .pop_data  (pop_beat),
    .full      (full),
    .empty     (empty)
  );

  // Egress shows the FIFO head and pops on each handshake
  assign m_axis_tvalid = ~empty;
  assign pop           = m_axis_tvalid & m_axis_tready;
  assign {m_axis_tdata, m_axis_tstrb, m_axis_tlast,
          m_axis_len, m_axis_spt, m_axis_dpt, m_axis_err} = pop_beat;

  // Packet boundary tracking and the two counters
  always_ff @(posedge ACLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= HEAD;
      ready_en_q <= 1'b0;
      fwd_cnt    <= '0;
      drop_cnt   <= '0;
    end else begin
      ready_en_q <= 1'b1;
      if (in_acc) begin
        if (s_axis_tlast) begin
          state_q <= HEAD;  // Single-beat packets never leave HEAD
          if (drop_now) drop_cnt <= drop_cnt + 1'b1;
          else fwd_cnt <= fwd_cnt + 1'b1;  // Counted as the last beat enters the FIFO
        end else if (state_q == HEAD) begin
          state_q <= drop_now ? BODY_DROP : BODY_FWD;
        end
      end
    end
  end

  // Head sideband is kept for the body beats
  always_ff @(posedge ACLK) begin
    if (in_acc && state_q == HEAD) side_q <= side_head;
  end

  // Egress payload must hold while the sink applies back-pressure
  a_egress_stable : assert property (@(posedge ACLK) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(pop_beat));

endmodule

// ==== design/nf_top.sv ====
// Stand-in FPGA top level with the control plane and data plane of the bridge
// Registers the XOR of the debug vector onto a single parity pin
`timescale 1ns/1ns

module nf_top
  import nf_pkg::*;
#(
  parameter int DATA_W     = 64,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                ACLK,
  input  logic                rst_n,
  // AXI4-Lite control bus from the bridge
  input  axil_addr_t          s_axi_awaddr,
  input  logic [2:0]          s_axi_awprot,
  input  logic                s_axi_awvalid,
  output logic                s_axi_awready,
  input  axil_data_t          s_axi_wdata,
  input  axil_strb_t          s_axi_wstrb,
  input  logic                s_axi_wvalid,
  output logic                s_axi_wready,
  output axi_resp_t           s_axi_bresp,
  output logic                s_axi_bvalid,
  input  logic                s_axi_bready,
  input  axil_addr_t          s_axi_araddr,
  input  logic [2:0]          s_axi_arprot,
  input  logic                s_axi_arvalid,
  output logic                s_axi_arready,
  output axil_data_t          s_axi_rdata,
  output axi_resp_t           s_axi_rresp,
  output logic                s_axi_rvalid,
  input  logic                s_axi_rready,
  // Ingress stream from the bridge
  input  logic [DATA_W-1:0]   s_axis_tdata,
  input  logic [DATA_W/8-1:0] s_axis_tstrb,
  input  logic                s_axis_tlast,
  input  logic                s_axis_tvalid,
  output logic                s_axis_tready,
  input  pkt_len_t            s_axis_len,
  input  port_t               s_axis_spt,
  input  port_t               s_axis_dpt,
  input  logic                s_axis_err,
  // Egress stream back to the bridge
  output logic [DATA_W-1:0]   m_axis_tdata,
  output logic [DATA_W/8-1:0] m_axis_tstrb,
  output logic                m_axis_tlast,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output pkt_len_t            m_axis_len,
  output port_t               m_axis_spt,
  output port_t               m_axis_dpt,
  output logic                m_axis_err,
  output logic                debug_parity  // Keeps the debug logic from being trimmed
);

  logic       swap_en;
  logic       drop_en;
  cnt_t       fwd_cnt;
  cnt_t       drop_cnt;
  axil_data_t debug_vec;

  // Control plane register file
  ctrl_regs ctrl_regs_inst (
    .ACLK          (ACLK),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arprot  (s_axi_arprot),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .fwd_cnt       (fwd_cnt),
    .drop_cnt      (drop_cnt),
    .swap_en       (swap_en),
    .drop_en       (drop_en),
    .debug_vec     (debug_vec)
  );

  // Data plane loopback from ingress to egress
  stream_loopback #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) stream_loopback_inst (
    .ACLK          (ACLK),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_len    (s_axis_len),
    .s_axis_spt    (s_axis_spt),
    .s_axis_dpt    (s_axis_dpt),
    .s_axis_err    (s_axis_err),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_len    (m_axis_len),
    .m_axis_spt    (m_axis_spt),
    .m_axis_dpt    (m_axis_dpt),
    .m_axis_err    (m_axis_err),
    .swap_en       (swap_en),
    .drop_en       (drop_en),
    .fwd_cnt       (fwd_cnt),
    .drop_cnt      (drop_cnt)
  );

  // One flop of XOR reduction over the debug bits
  always_ff @(posedge ACLK or negedge rst_n) begin
    if (!rst_n) debug_parity <= 1'b0;
    else debug_parity <= ^debug_vec;  // Lags the register contents by one cycle
  end

endmodule

// ==== tb/tb_top.sv ====
// Testbench for the bridge stand-in with AXI-Lite and stream drivers and a reference model
// Random packets and register traffic checked by typed compare tasks and a final report
`timescale 1ns/1ns

module tb_top
  import nf_pkg::*;
();

  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;
  localparam int FIFO_DEPTH = 8;
  localparam int BW = DATA_W + STRB_W + 1 + $bits(pkt_len_t) + 2 * $bits(port_t) + 1;

  logic ACLK;
  logic rst_n;
  axil_addr_t s_axi_awaddr, s_axi_araddr;
  logic [2:0] s_axi_awprot, s_axi_arprot;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  axil_data_t s_axi_wdata, s_axi_rdata;
  axil_strb_t s_axi_wstrb;
  axi_resp_t s_axi_bresp, s_axi_rresp;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  logic [DATA_W-1:0] s_axis_tdata, m_axis_tdata;
  logic [STRB_W-1:0] s_axis_tstrb, m_axis_tstrb;
  logic s_axis_tlast, s_axis_tvalid, s_axis_tready, s_axis_err;
  logic m_axis_tlast, m_axis_tvalid, m_axis_tready, m_axis_err;
  pkt_len_t s_axis_len, m_axis_len;
  port_t s_axis_spt, s_axis_dpt, m_axis_spt, m_axis_dpt;
  logic debug_parity;

  // Reference model of the register file and the loopback
  axil_data_t model_scratch;
  logic [7:0] model_ctrl;
  cnt_t       model_fwd;
  cnt_t       model_drop;
  logic [BW-1:0] in_q[$];   // Ingress beats still to send
  logic [BW-1:0] exp_q[$];  // Egress beats the model expects, in order

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycle_cnt = 0;
  int beats_sent = 0;

  nf_top #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) nf_top_inst (.*);

  always #4 ACLK = ~ACLK;  // 8 ns period

  // Run limit grows with the traffic actually sent
  always @(posedge ACLK) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * beats_sent + 2000) begin
      $display("Timeout: run stopped after %0d cycles with %0d beats sent", cycle_cnt, beats_sent);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_resp(input string name, input axi_resp_t exp_v, input axi_resp_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input axil_data_t exp_v, input axil_data_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_beat(input logic [DATA_W-1:0] exp_d, input logic [STRB_W-1:0] exp_s,
                            input logic exp_l, input logic [DATA_W-1:0] act_d,
                            input logic [STRB_W-1:0] act_s, input logic act_l);
    if ({act_d, act_s, act_l} !== {exp_d, exp_s, exp_l}) begin
      $display("CHECK FAILED at %0t: m_axis_tdata/tstrb/tlast expected %h/%h/%b, got %h/%h/%b",
               $time, exp_d, exp_s, exp_l, act_d, act_s, act_l);
      errors++;
    end
  endtask

  task automatic check_side(input pkt_len_t exp_len, input port_t exp_spt, input port_t exp_dpt,
                            input logic exp_err, input pkt_len_t act_len, input port_t act_spt,
                            input port_t act_dpt, input logic act_err);
    if ({act_len, act_spt, act_dpt, act_err} !== {exp_len, exp_spt, exp_dpt, exp_err}) begin
      $display("CHECK FAILED at %0t: m_axis_len/spt/dpt/err expected %h/%h/%h/%b, got %h/%h/%h/%b",
               $time, exp_len, exp_spt, exp_dpt, exp_err, act_len, act_spt, act_dpt, act_err);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  // One AXI-Lite write with a random start delay and random bready stalls
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, output axi_resp_t resp);
    repeat ($urandom_range(2)) @(negedge ACLK);
    @(negedge ACLK);
    s_axi_awaddr  = addr;
    s_axi_awprot  = 3'($urandom);  // Protection bits carry no meaning here
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    #1;
    while (!s_axi_awready) begin
      @(negedge ACLK);
      #1;
    end
    check_bit("s_axi_wready", 1'b1, s_axi_wready);  // Data channel is taken with the address
    @(negedge ACLK);  // Accepted on the edge just passed
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    forever begin
      s_axi_bready = 1'($urandom_range(1));
      #1;
      if (s_axi_bvalid && s_axi_bready) break;
      @(negedge ACLK);
    end
    resp = s_axi_bresp;
    @(negedge ACLK);
    s_axi_bready = 1'b0;
  endtask

  // One AXI-Lite read with the same kind of random delays
  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axi_resp_t resp);
    repeat ($urandom_range(2)) @(negedge ACLK);
    @(negedge ACLK);
    s_axi_araddr  = addr;
    s_axi_arprot  = 3'($urandom);
    s_axi_arvalid = 1'b1;
    #1;
    while (!s_axi_arready) begin
      @(negedge ACLK);
      #1;
    end
    @(negedge ACLK);
    s_axi_arvalid = 1'b0;
    forever begin
      s_axi_rready = 1'($urandom_range(1));
      #1;
      if (s_axi_rvalid && s_axi_rready) break;
      @(negedge ACLK);
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(negedge ACLK);
    s_axi_rready = 1'b0;
  endtask

  // Writes, updates the model, then checks the response and the parity pin
  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
    axi_resp_t resp;
    axi_resp_t exp_resp;
    exp_resp = RESP_SLVERR;  // ID, counters and holes are not writable
    if (addr == REG_SCRATCH) begin
      exp_resp = RESP_OKAY;
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) model_scratch[8*i +: 8] = data[8*i +: 8];
      end
    end else if (addr == REG_CTRL) begin
      exp_resp = RESP_OKAY;
      if (strb[0]) model_ctrl = data[7:0];
    end
    axil_write(addr, data, strb, resp);
    check_resp("s_axi_bresp", exp_resp, resp);
    repeat (2) @(negedge ACLK);
    check_bit("debug_parity", ^(model_scratch ^ {24'h0, model_ctrl}), debug_parity);
  endtask

  task automatic read_reg(input axil_addr_t addr);
    axil_data_t data;
    axil_data_t exp_data;
    axi_resp_t  resp;
    axi_resp_t  exp_resp;
    exp_resp = RESP_OKAY;
    case (addr)
      REG_ID:       exp_data = DESIGN_ID;
      REG_SCRATCH:  exp_data = model_scratch;
      REG_CTRL:     exp_data = {24'h0, model_ctrl};
      REG_FWD_CNT:  exp_data = model_fwd;
      REG_DROP_CNT: exp_data = model_drop;
      default: begin
        exp_data = '0;  // Holes read as zero with an error
        exp_resp = RESP_SLVERR;
      end
    endcase
    axil_read(addr, data, resp);
    check_reg($sformatf("s_axi_rdata[%h]", addr), exp_data, data);
    check_resp("s_axi_rresp", exp_resp, resp);
  endtask

  // Builds random packets and the egress the current control value implies
  task automatic gen_packets(input int n);
    int nbeats;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic last;
    pkt_len_t len;
    port_t spt;
    port_t dpt;
    logic err;
    logic drop;
    logic swap;
    for (int p = 0; p < n; p++) begin
      nbeats = $urandom_range(6, 1);
      len  = pkt_len_t'(nbeats * STRB_W - int'($urandom_range(STRB_W - 1)));
      spt  = port_t'($urandom);
      dpt  = port_t'($urandom);
      err  = ($urandom_range(2) == 0);  // About one packet in three is bad
      drop = model_ctrl[CTRL_DROP_BIT] & err;
      swap = model_ctrl[CTRL_SWAP_BIT];
      for (int b = 0; b < nbeats; b++) begin
        data = {$urandom, $urandom};
        strb = STRB_W'($urandom);
        last = (b == nbeats - 1);
        in_q.push_back({data, strb, last, len, spt, dpt, err});
        if (!drop && swap) exp_q.push_back({data, strb, last, len, dpt, spt, err});
        else if (!drop) exp_q.push_back({data, strb, last, len, spt, dpt, err});
      end
      if (drop) model_drop++;
      else model_fwd++;
    end
  endtask

  // Ingress master holds each beat until it is taken
  task automatic send_stream();
    logic busy;
    busy = 1'b0;
    while (in_q.size() > 0) begin
      @(negedge ACLK);
      if (!busy && $urandom_range(3) == 0) begin
        s_axis_tvalid = 1'b0;  // Idle gap between beats
      end else if (!busy) begin
        {s_axis_tdata, s_axis_tstrb, s_axis_tlast,
         s_axis_len, s_axis_spt, s_axis_dpt, s_axis_err} = in_q[0];
        s_axis_tvalid = 1'b1;
        busy = 1'b1;
      end
      #1;
      if (busy && s_axis_tready) begin
        void'(in_q.pop_front());
        beats_sent++;
        busy = 1'b0;
      end
    end
    @(negedge ACLK);
    s_axis_tvalid = 1'b0;
  endtask

  // Egress slave with random back-pressure compares every beat in order
  task automatic recv_stream();
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    logic l;
    pkt_len_t len;
    port_t spt;
    port_t dpt;
    logic err;
    while (exp_q.size() > 0) begin
      @(negedge ACLK);
      m_axis_tready = ($urandom_range(2) != 0);
      #1;
      if (m_axis_tvalid && m_axis_tready) begin
        {d, s, l, len, spt, dpt, err} = exp_q.pop_front();
        check_beat(d, s, l, m_axis_tdata, m_axis_tstrb, m_axis_tlast);
        check_side(len, spt, dpt, err, m_axis_len, m_axis_spt, m_axis_dpt, m_axis_err);
      end
    end
    @(negedge ACLK);
    m_axis_tready = 1'b0;
  endtask

  task automatic run_packets(input int n);
    int extra;
    extra = 0;
    gen_packets(n);
    fork
      send_stream();
      recv_stream();
    join
    repeat (FIFO_DEPTH + 4) begin
      @(negedge ACLK);
      if (m_axis_tvalid) extra++;  // Anything left over was never expected
    end
    if (extra != 0) begin
      $display("Egress still offers a beat at %0t that the model did not expect", $time);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - mark);
    end
  endtask

  initial begin
    int mark;
    axil_addr_t hole;
    void'($urandom(32'h779d_c6f1));
    ACLK = 1'b0;
    rst_n = 1'b0;
    {s_axi_awaddr, s_axi_awprot, s_axi_awvalid, s_axi_wdata, s_axi_wstrb, s_axi_wvalid} = '0;
    {s_axi_bready, s_axi_araddr, s_axi_arprot, s_axi_arvalid, s_axi_rready} = '0;
    {s_axis_tdata, s_axis_tstrb, s_axis_tlast, s_axis_tvalid} = '0;
    {s_axis_len, s_axis_spt, s_axis_dpt, s_axis_err, m_axis_tready} = '0;
    model_scratch = '0;
    model_ctrl = '0;
    model_fwd = '0;
    model_drop = '0;
    repeat (3) @(posedge ACLK);
    @(negedge ACLK);
    rst_n = 1'b1;

    mark = errors;
    read_reg(REG_ID);
    for (int i = 0; i < 8; i++) begin
      write_reg(REG_SCRATCH, $urandom, 4'($urandom));  // Partial strobes merge byte by byte
      read_reg(REG_SCRATCH);
    end
    write_reg(REG_CTRL, $urandom, 4'($urandom));
    read_reg(REG_CTRL);
    write_reg(REG_ID, $urandom, 4'hF);
    write_reg(REG_FWD_CNT, $urandom, 4'hF);
    write_reg(REG_DROP_CNT, $urandom, 4'hF);
    read_reg(REG_ID);
    read_reg(REG_FWD_CNT);
    read_reg(REG_DROP_CNT);
    for (int i = 0; i < 4; i++) begin
      hole = axil_addr_t'(($urandom_range(1023) + 5) * 4);  // Word offsets past the map
      write_reg(hole, $urandom, 4'hF);
      read_reg(hole);
    end
    finish_test("register map", mark);

    mark = errors;
    write_reg(REG_CTRL, 32'h0, 4'h1);
    run_packets(24);  // Bad packets pass while drop is clear
    finish_test("plain loopback", mark);

    mark = errors;
    write_reg(REG_CTRL, 32'h1 << CTRL_SWAP_BIT, 4'h1);
    run_packets(24);
    finish_test("port swap", mark);

    mark = errors;
    write_reg(REG_CTRL, 32'h1 << CTRL_DROP_BIT, 4'h1);
    run_packets(24);
    write_reg(REG_CTRL, 32'h3, 4'h1);  // Swap and drop together
    run_packets(16);
    finish_test("error drop", mark);

    mark = errors;
    read_reg(REG_FWD_CNT);
    read_reg(REG_DROP_CNT);
    finish_test("packet counters", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      write_reg((i % 2 == 0) ? REG_SCRATCH : REG_CTRL, $urandom, 4'($urandom));
    end
    read_reg(REG_SCRATCH);
    read_reg(REG_CTRL);
    finish_test("debug parity", mark);

    $display("Tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/nf_pkg.sv
design/beat_fifo.sv
design/ctrl_regs.sv
design/stream_loopback.sv
design/nf_top.sv
tb/tb_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := tb.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
